/* demo_bus_top.f */
+incdir+rtl
rtl/demo_bus_pkg.sv
rtl/bus_if.sv
rtl/bus_xbar.sv
rtl/sram_dev.sv
rtl/timer_dev.sv
rtl/copy_engine.sv
rtl/demo_bus_top.sv
testbench/tb_demo_bus_top.sv

/* rtl/bus_if.sv */
//**********************************************************
// One bus channel. Responses come one cycle after gnt,
// one outstanding request per host, no back-pressure.
//**********************************************************

`include "demo_bus_cfg.svh"

interface bus_if;

  // Request side
  logic                        req;
  logic                        gnt;
  logic [`DEMO_BUS_AW-1:0]     addr;
  logic                        we;
  logic [`DEMO_BUS_DW/8-1:0]   be;
  logic [`DEMO_BUS_DW-1:0]     wdata;

  // Response side, valid for one cycle
  logic                        rvalid;
  logic [`DEMO_BUS_DW-1:0]     rdata;
  logic                        err;

  modport host (
    output req,
    output addr,
    output we,
    output be,
    output wdata,
    input  gnt,
    input  rvalid,
    input  rdata,
    input  err
  );

  modport device (
    input  req,
    input  addr,
    input  we,
    input  be,
    input  wdata,
    output gnt,
    output rvalid,
    output rdata,
    output err
  );

endinterface

/* rtl/bus_xbar.sv */
//**********************************************************
// Two hosts to two devices, fixed priority (host 0 first).
// Devices must answer one cycle after a request.
//**********************************************************

`include "demo_bus_cfg.svh"

module bus_xbar (
  input  logic  clk_i,
  input  logic  rst_ni,
  bus_if.device host_bus [2],
  bus_if.host   dev_bus  [2]
);

  localparam int NumHosts = 2;
  localparam int NumDevs  = 2;
  localparam int HostSelW = $clog2(NumHosts);
  localparam int DevSelW  = $clog2(NumDevs);

  localparam logic [`DEMO_BUS_AW-1:0] DevBase [NumDevs] =
    '{`DEMO_BUS_SRAM_BASE, `DEMO_BUS_TIMER_BASE};
  localparam logic [`DEMO_BUS_AW-1:0] DevMask [NumDevs] =
    '{`DEMO_BUS_SRAM_MASK, `DEMO_BUS_TIMER_MASK};

  // Flattened host side
  logic [NumHosts-1:0]       h_req;
  logic [`DEMO_BUS_AW-1:0]   h_addr   [NumHosts];
  logic [NumHosts-1:0]       h_we;
  logic [`DEMO_BUS_DW/8-1:0] h_be     [NumHosts];
  logic [`DEMO_BUS_DW-1:0]   h_wdata  [NumHosts];
  logic [NumHosts-1:0]       h_gnt;
  logic [NumHosts-1:0]       h_rvalid;
  logic [`DEMO_BUS_DW-1:0]   h_rdata  [NumHosts];
  logic [NumHosts-1:0]       h_err;

  // Flattened device side
  logic [NumDevs-1:0]        d_req;
  logic [`DEMO_BUS_AW-1:0]   d_addr   [NumDevs];
  logic [NumDevs-1:0]        d_we;
  logic [`DEMO_BUS_DW/8-1:0] d_be     [NumDevs];
  logic [`DEMO_BUS_DW-1:0]   d_wdata  [NumDevs];
  logic [NumDevs-1:0]        d_gnt;
  logic [NumDevs-1:0]        d_rvalid;
  logic [`DEMO_BUS_DW-1:0]   d_rdata  [NumDevs];
  logic [NumDevs-1:0]        d_err;

  logic                any_req;
  logic [HostSelW-1:0] host_sel;
  logic                dev_hit;
  logic [DevSelW-1:0]  dev_sel;
  logic                granted;

  logic                resp_q;
  logic                miss_q;
  logic [HostSelW-1:0] host_sel_q;
  logic [DevSelW-1:0]  dev_sel_q;

  for (genvar h = 0; h < NumHosts; h++) begin : g_host
    assign h_req[h]            = host_bus[h].req;
    assign h_addr[h]           = host_bus[h].addr;
    assign h_we[h]             = host_bus[h].we;
    assign h_be[h]             = host_bus[h].be;
    assign h_wdata[h]          = host_bus[h].wdata;
    assign host_bus[h].gnt     = h_gnt[h];
    assign host_bus[h].rvalid  = h_rvalid[h];
    assign host_bus[h].rdata   = h_rdata[h];
    assign host_bus[h].err     = h_err[h];

    // Responses only go back to the host granted one cycle earlier
    a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      h_rvalid[h] |-> $past(h_gnt[h]));
  end

  for (genvar d = 0; d < NumDevs; d++) begin : g_dev
    assign dev_bus[d].req   = d_req[d];
    assign dev_bus[d].addr  = d_addr[d];
    assign dev_bus[d].we    = d_we[d];
    assign dev_bus[d].be    = d_be[d];
    assign dev_bus[d].wdata = d_wdata[d];
    assign d_gnt[d]         = dev_bus[d].gnt;
    assign d_rvalid[d]      = dev_bus[d].rvalid;
    assign d_rdata[d]       = dev_bus[d].rdata;
    assign d_err[d]         = dev_bus[d].err;
  end

  // Lowest requesting host index wins
  always_comb begin
    any_req  = 1'b0;
    host_sel = '0;
    for (int h = NumHosts - 1; h >= 0; h--) begin
      if (h_req[h]) begin
        any_req  = 1'b1;
        host_sel = HostSelW'(h);
      end
    end
  end

  // Address decode, a later match overrides an earlier one
  always_comb begin
    dev_hit = 1'b0;
    dev_sel = '0;
    for (int d = 0; d < NumDevs; d++) begin
      if ((h_addr[host_sel] & DevMask[d]) == DevBase[d]) begin
        dev_hit = 1'b1;
        dev_sel = DevSelW'(d);
      end
    end
  end

  // Only the selected device sees the request
  always_comb begin
    for (int d = 0; d < NumDevs; d++) begin
      if (dev_hit && (dev_sel == DevSelW'(d))) begin
        d_req[d]   = any_req;
        d_addr[d]  = h_addr[host_sel];
        d_we[d]    = h_we[host_sel];
        d_be[d]    = h_be[host_sel];
        d_wdata[d] = h_wdata[host_sel];
      end else begin
        d_req[d]   = 1'b0;
        d_addr[d]  = '0;
        d_we[d]    = 1'b0;
        d_be[d]    = '0;
        d_wdata[d] = '0;
      end
    end
  end

  // Unmapped requests are granted by the crossbar itself
  assign granted = any_req & (dev_hit ? d_gnt[dev_sel] : 1'b1);

  always_comb begin
    h_gnt           = '0;
    h_gnt[host_sel] = granted;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_q     <= 1'b0;
      miss_q     <= 1'b0;
      host_sel_q <= '0;
      dev_sel_q  <= '0;
    end else begin
      resp_q     <= granted;
      miss_q     <= granted & ~dev_hit;
      host_sel_q <= host_sel;
      dev_sel_q  <= dev_sel;
    end
  end

  // Response steering, error with zero data on a miss
  always_comb begin
    for (int h = 0; h < NumHosts; h++) begin
      h_rvalid[h] = 1'b0;
      h_rdata[h]  = '0;
      h_err[h]    = 1'b0;
      if (resp_q && (host_sel_q == HostSelW'(h))) begin
        if (miss_q) begin
          h_rvalid[h] = 1'b1;
          h_err[h]    = 1'b1;
        end else begin
          h_rvalid[h] = d_rvalid[dev_sel_q];
          h_rdata[h]  = d_rdata[dev_sel_q];
          h_err[h]    = d_err[dev_sel_q];
        end
      end
    end
  end

  // One grant at most, only to a requester and never past host 0
  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((h_gnt & ~h_req) == '0) && !(h_gnt[1] && h_req[0]));

endmodule

/* rtl/copy_engine.sv */
//**********************************************************
// Word copy engine, one read then one write per word.
// Addresses must be word aligned, len_i counts words.
//**********************************************************

`include "demo_bus_cfg.svh"

module copy_engine (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  logic [`DEMO_BUS_AW-1:0] src_addr_i,
  input  logic [`DEMO_BUS_AW-1:0] dst_addr_i,
  input  logic [15:0]             len_i,
  output logic                    busy_o,
  output logic                    done_o,
  output logic                    err_o,
  bus_if.host                     bus
);

  localparam int WordBytes = `DEMO_BUS_DW / 8;

  demo_bus_pkg::copy_state_e state_q;
  demo_bus_pkg::copy_state_e state_d;

  logic [`DEMO_BUS_AW-1:0] src_q;
  logic [`DEMO_BUS_AW-1:0] dst_q;
  logic [15:0]             remain_q;
  logic [`DEMO_BUS_DW-1:0] data_q;
  logic                    err_q;
  logic                    resp_wait;

  assign resp_wait = (state_q == demo_bus_pkg::COPY_RD_WAIT) ||
                     (state_q == demo_bus_pkg::COPY_WR_WAIT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      demo_bus_pkg::COPY_IDLE: begin
        if (start_i) begin
          state_d = (len_i == '0) ? demo_bus_pkg::COPY_DONE : demo_bus_pkg::COPY_RD_REQ;
        end
      end
      demo_bus_pkg::COPY_RD_REQ: begin
        if (bus.gnt) state_d = demo_bus_pkg::COPY_RD_WAIT;
      end
      demo_bus_pkg::COPY_RD_WAIT: begin
        if (bus.rvalid) begin
          state_d = bus.err ? demo_bus_pkg::COPY_DONE : demo_bus_pkg::COPY_WR_REQ;
        end
      end
      demo_bus_pkg::COPY_WR_REQ: begin
        if (bus.gnt) state_d = demo_bus_pkg::COPY_WR_WAIT;
      end
      demo_bus_pkg::COPY_WR_WAIT: begin
        if (bus.rvalid) begin
          // Last word or a failed write ends the copy
          if (bus.err || (remain_q == 16'd1)) state_d = demo_bus_pkg::COPY_DONE;
          else state_d = demo_bus_pkg::COPY_RD_REQ;
        end
      end
      default: state_d = demo_bus_pkg::COPY_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= demo_bus_pkg::COPY_IDLE;
      src_q    <= '0;
      dst_q    <= '0;
      remain_q <= '0;
      err_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if ((state_q == demo_bus_pkg::COPY_IDLE) && start_i) begin
        src_q    <= src_addr_i;
        dst_q    <= dst_addr_i;
        remain_q <= len_i;
        err_q    <= 1'b0;
      end
      if (resp_wait && bus.rvalid && bus.err) begin
        err_q <= 1'b1;
      end
      if ((state_q == demo_bus_pkg::COPY_WR_WAIT) && bus.rvalid && !bus.err) begin
        src_q    <= src_q + WordBytes;
        dst_q    <= dst_q + WordBytes;
        remain_q <= remain_q - 16'd1;
      end
    end
  end

  // Word in flight between the read and the write
  always_ff @(posedge clk_i) begin
    if ((state_q == demo_bus_pkg::COPY_RD_WAIT) && bus.rvalid) begin
      data_q <= bus.rdata;
    end
  end

  assign bus.req   = (state_q == demo_bus_pkg::COPY_RD_REQ) ||
                     (state_q == demo_bus_pkg::COPY_WR_REQ);
  assign bus.we    = (state_q == demo_bus_pkg::COPY_WR_REQ);
  assign bus.addr  = bus.we ? dst_q : src_q;
  assign bus.be    = '1;
  assign bus.wdata = data_q;

  assign busy_o = (state_q != demo_bus_pkg::COPY_IDLE);
  assign done_o = (state_q == demo_bus_pkg::COPY_DONE);
  assign err_o  = err_q;

  // A request that lost arbitration is held unchanged
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.req && !bus.gnt |=> bus.req && $stable(bus.addr) && $stable(bus.we));

endmodule

/* rtl/demo_bus_cfg.svh */
//**********************************************************
// Bus widths and device address map for the demo bus.
// Base and mask pairs must not leave gaps inside a region.
//**********************************************************

`ifndef DEMO_BUS_CFG_SVH
`define DEMO_BUS_CFG_SVH

// Bus widths in bits
`define DEMO_BUS_DW 32
`define DEMO_BUS_AW 32

// SRAM depth in words, must fill the SRAM region
`define DEMO_BUS_SRAM_WORDS 1024

// Device 0, 4 KiB SRAM
`define DEMO_BUS_SRAM_BASE 32'h0000_0000
`define DEMO_BUS_SRAM_MASK 32'hFFFF_F000

// Device 1, four timer registers
`define DEMO_BUS_TIMER_BASE 32'h0001_0000
`define DEMO_BUS_TIMER_MASK 32'hFFFF_FFF0

`endif

/* rtl/demo_bus_pkg.sv */
//**********************************************************
// Shared types of the demo bus system
//**********************************************************

package demo_bus_pkg;

  // Copy engine FSM states
  typedef enum logic [2:0] {
    COPY_IDLE    = 3'd0,
    COPY_RD_REQ  = 3'd1,
    COPY_RD_WAIT = 3'd2,
    COPY_WR_REQ  = 3'd3,
    COPY_WR_WAIT = 3'd4,
    COPY_DONE    = 3'd5
  } copy_state_e;

  // Timer register word offsets, offset 3 is unused
  typedef enum logic [1:0] {
    TMR_CTRL    = 2'd0,
    TMR_COUNT   = 2'd1,
    TMR_COMPARE = 2'd2
  } timer_reg_e;

endpackage

/* rtl/demo_bus_top.sv */
//**********************************************************
// Demo bus system. Host 0 comes from the ports, host 1 is
// the copy engine. SRAM and timer map from the cfg header.
//**********************************************************

`include "demo_bus_cfg.svh"

module demo_bus_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Host 0
  input  logic                      host_req_i,
  output logic                      host_gnt_o,
  input  logic [`DEMO_BUS_AW-1:0]   host_addr_i,
  input  logic                      host_we_i,
  input  logic [`DEMO_BUS_DW/8-1:0] host_be_i,
  input  logic [`DEMO_BUS_DW-1:0]   host_wdata_i,
  output logic                      host_rvalid_o,
  output logic [`DEMO_BUS_DW-1:0]   host_rdata_o,
  output logic                      host_err_o,

  // Copy engine
  input  logic                      copy_start_i,
  input  logic [`DEMO_BUS_AW-1:0]   copy_src_i,
  input  logic [`DEMO_BUS_AW-1:0]   copy_dst_i,
  input  logic [15:0]               copy_len_i,
  output logic                      copy_busy_o,
  output logic                      copy_done_o,
  output logic                      copy_err_o,

  output logic                      timer_irq_o
);

  bus_if host_bus [2] ();
  bus_if dev_bus  [2] ();

  assign host_bus[0].req   = host_req_i;
  assign host_bus[0].addr  = host_addr_i;
  assign host_bus[0].we    = host_we_i;
  assign host_bus[0].be    = host_be_i;
  assign host_bus[0].wdata = host_wdata_i;
  assign host_gnt_o        = host_bus[0].gnt;
  assign host_rvalid_o     = host_bus[0].rvalid;
  assign host_rdata_o      = host_bus[0].rdata;
  assign host_err_o        = host_bus[0].err;

  copy_engine u_copy (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (copy_start_i),
    .src_addr_i (copy_src_i),
    .dst_addr_i (copy_dst_i),
    .len_i      (copy_len_i),
    .busy_o     (copy_busy_o),
    .done_o     (copy_done_o),
    .err_o      (copy_err_o),
    .bus        (host_bus[1])
  );

  bus_xbar u_xbar (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .host_bus (host_bus),
    .dev_bus  (dev_bus)
  );

  sram_dev u_sram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (dev_bus[0])
  );

  timer_dev u_timer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (dev_bus[1]),
    .irq_o  (timer_irq_o)
  );

endmodule

/* rtl/sram_dev.sv */
//**********************************************************
// Word SRAM, always grants, answers the next cycle.
// Reads see the old word when written in the same cycle.
//**********************************************************

`include "demo_bus_cfg.svh"

module sram_dev (
  input  logic  clk_i,
  input  logic  rst_ni,
  bus_if.device bus
);

  localparam int IdxW = $clog2(`DEMO_BUS_SRAM_WORDS);

  logic [`DEMO_BUS_DW-1:0] mem [`DEMO_BUS_SRAM_WORDS];
  logic [IdxW-1:0]         word_idx;
  logic                    rvalid_q;
  logic [`DEMO_BUS_DW-1:0] rdata_q;

  // Byte address to word index
  assign word_idx = bus.addr[IdxW+1:2];

  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= mem[word_idx];
      if (bus.we) begin
        for (int b = 0; b < `DEMO_BUS_DW / 8; b++) begin
          if (bus.be[b]) begin
            mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Exactly one response per request, one cycle later
  a_resp_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.req |=> bus.rvalid);
  a_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.rvalid |-> $past(bus.req));

endmodule

/* rtl/timer_dev.sv */
//**********************************************************
// Free-running timer, byte enables are ignored.
// irq is a level, cleared only by a write to CTRL.
//**********************************************************

`include "demo_bus_cfg.svh"

module timer_dev (
  input  logic  clk_i,
  input  logic  rst_ni,
  bus_if.device bus,
  output logic  irq_o
);

  demo_bus_pkg::timer_reg_e reg_sel;

  logic                    enable_q;
  logic [`DEMO_BUS_DW-1:0] count_q;
  logic [`DEMO_BUS_DW-1:0] compare_q;
  logic                    irq_q;
  logic                    rvalid_q;
  logic                    err_q;
  logic [`DEMO_BUS_DW-1:0] rdata_q;

  logic                    wr_ctrl;
  logic                    wr_count;
  logic                    wr_compare;
  logic                    bad_off;
  logic [`DEMO_BUS_DW-1:0] rd_val;

  assign reg_sel = demo_bus_pkg::timer_reg_e'(bus.addr[3:2]);

  always_comb begin
    wr_ctrl    = 1'b0;
    wr_count   = 1'b0;
    wr_compare = 1'b0;
    bad_off    = 1'b0;
    rd_val     = '0;
    case (reg_sel)
      demo_bus_pkg::TMR_CTRL: begin
        wr_ctrl = bus.req & bus.we;
        rd_val  = {{(`DEMO_BUS_DW-1){1'b0}}, enable_q};
      end
      demo_bus_pkg::TMR_COUNT: begin
        wr_count = bus.req & bus.we;
        rd_val   = count_q;
      end
      demo_bus_pkg::TMR_COMPARE: begin
        wr_compare = bus.req & bus.we;
        rd_val     = compare_q;
      end
      default: bad_off = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q  <= 1'b0;
      count_q   <= '0;
      compare_q <= '0;
      irq_q     <= 1'b0;
      rvalid_q  <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      err_q    <= bus.req & bad_off;
      if (wr_ctrl) begin
        enable_q <= bus.wdata[0];
      end
      // A COUNT write overrides the increment
      if (wr_count) begin
        count_q <= bus.wdata;
      end else if (enable_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr_compare) begin
        compare_q <= bus.wdata;
      end
      if (wr_ctrl) begin
        irq_q <= 1'b0;
      end else if (enable_q && (count_q == compare_q)) begin
        irq_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= rd_val;
    end
  end

  assign bus.gnt    = bus.req;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;
  assign irq_o      = irq_q;

endmodule

/* testbench/tb_demo_bus_top.sv */
//**********************************************************
// Testbench for the demo bus system. Host 0 traffic stays in
// SRAM words 768..1023, copy blocks use the lower words.
//**********************************************************

`include "demo_bus_cfg.svh"

module tb_demo_bus_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WaitLimit = 200;
  localparam int CopyLimit = 2000;
  localparam logic [31:0] TimerBase = `DEMO_BUS_TIMER_BASE;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        host_req;
  logic        host_gnt;
  logic [31:0] host_addr;
  logic        host_we;
  logic [3:0]  host_be;
  logic [31:0] host_wdata;
  logic        host_rvalid;
  logic [31:0] host_rdata;
  logic        host_err;
  logic        copy_start;
  logic [31:0] copy_src;
  logic [31:0] copy_dst;
  logic [15:0] copy_len;
  logic        copy_busy;
  logic        copy_done;
  logic        copy_err;
  logic        timer_irq;

  // Expected response of the current host 0 request
  logic        chk_data;
  logic [31:0] exp_rdata;
  logic        exp_err;
  logic        exp_copy_err;

  // Same values, one cycle later, for the response cycle
  logic        resp_due;
  logic        resp_chk;
  logic        resp_err;
  logic [31:0] resp_data;

  logic [31:0] model [1024];
  logic [31:0] lcg_state = 32'hb4e9_77e7;
  logic        ctrl_wr;
  int          done_cnt;
  int          overlap_cnt;
  int          value_errs = 0;
  int          proto_errs = 0;
  int          timeout_errs = 0;

  always #4 clk = ~clk;

  demo_bus_top u_dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .host_req_i    (host_req),
    .host_gnt_o    (host_gnt),
    .host_addr_i   (host_addr),
    .host_we_i     (host_we),
    .host_be_i     (host_be),
    .host_wdata_i  (host_wdata),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .host_err_o    (host_err),
    .copy_start_i  (copy_start),
    .copy_src_i    (copy_src),
    .copy_dst_i    (copy_dst),
    .copy_len_i    (copy_len),
    .copy_busy_o   (copy_busy),
    .copy_done_o   (copy_done),
    .copy_err_o    (copy_err),
    .timer_irq_o   (timer_irq)
  );

  assign ctrl_wr = host_req && host_gnt && host_we && (host_addr == TimerBase);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_due    <= 1'b0;
      resp_chk    <= 1'b0;
      resp_err    <= 1'b0;
      resp_data   <= '0;
      done_cnt    <= 0;
      overlap_cnt <= 0;
    end else begin
      resp_due  <= host_req && host_gnt;
      resp_chk  <= host_req && host_gnt && !host_we && chk_data;
      resp_err  <= exp_err;
      resp_data <= exp_rdata;
      if (copy_done) begin
        done_cnt <= done_cnt + 1;
      end
      if (host_req && u_dut.host_bus[1].req) begin
        overlap_cnt <= overlap_cnt + 1;
      end
    end
  end

  // Host 0 response rules
  a_rvalid_on_time: assert property (@(posedge clk) disable iff (!rst_n)
    resp_due |-> host_rvalid)
    else begin
      value_errs++;
      $display("[FAIL] %0t host_rvalid_o expected 1 got 0", $time);
    end
  a_rvalid_only: assert property (@(posedge clk) disable iff (!rst_n)
    host_rvalid |-> resp_due)
    else begin
      value_errs++;
      $display("[FAIL] %0t host_rvalid_o expected 0 got 1", $time);
    end
  a_err_value: assert property (@(posedge clk) disable iff (!rst_n)
    host_rvalid |-> host_err == resp_err)
    else begin
      value_errs++;
      $display("[FAIL] %0t host_err_o expected %b got %b", $time,
               $sampled(resp_err), $sampled(host_err));
    end
  a_rdata_value: assert property (@(posedge clk) disable iff (!rst_n)
    host_rvalid && resp_chk |-> host_rdata == resp_data)
    else begin
      value_errs++;
      $display("[FAIL] %0t host_rdata_o expected %h got %h", $time,
               $sampled(resp_data), $sampled(host_rdata));
    end

  // Host 0 always wins against the copy engine
  a_priority: assert property (@(posedge clk) disable iff (!rst_n)
    host_req && u_dut.host_bus[1].req |-> host_gnt && !u_dut.host_bus[1].gnt)
    else begin
      value_errs++;
      $display("[FAIL] %0t host_gnt_o expected 1 got %b", $time, $sampled(host_gnt));
    end

  // Timer interrupt level
  a_irq_hold: assert property (@(posedge clk) disable iff (!rst_n)
    timer_irq && !ctrl_wr |=> timer_irq)
    else begin
      value_errs++;
      $display("[FAIL] %0t timer_irq_o expected 1 got 0", $time);
    end
  a_irq_clear: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_wr |=> !timer_irq)
    else begin
      value_errs++;
      $display("[FAIL] %0t timer_irq_o expected 0 got 1", $time);
    end

  // Copy engine status
  a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
    copy_start && !copy_busy |=> copy_busy)
    else begin
      value_errs++;
      $display("[FAIL] %0t copy_busy_o expected 1 got 0", $time);
    end
  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    copy_done |=> !copy_done && !copy_busy)
    else begin
      value_errs++;
      $display("[FAIL] %0t copy_done_o/copy_busy_o expected 0/0 got %b/%b", $time,
               $sampled(copy_done), $sampled(copy_busy));
    end
  a_copy_err: assert property (@(posedge clk) disable iff (!rst_n)
    copy_done |-> copy_err == exp_copy_err)
    else begin
      value_errs++;
      $display("[FAIL] %0t copy_err_o expected %b got %b", $time,
               $sampled(exp_copy_err), $sampled(copy_err));
    end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic finish_run();
    $display("Errors: %0d value, %0d protocol, %0d timeout",
             value_errs, proto_errs, timeout_errs);
    if (value_errs + proto_errs + timeout_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeout_errs++;
    $display("Timeout at %0t while waiting for %s", $time, what);
    disable test_seq;
  endtask

  // Called at a negedge, returns at the negedge of the response cycle
  task automatic bus_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                            input logic [31:0] wdata, input logic chk,
                            input logic [31:0] exp_data, input logic exp_fail,
                            output logic [31:0] rdata);
    int waited;
    host_req   = 1'b1;
    host_addr  = addr;
    host_we    = we;
    host_be    = be;
    host_wdata = wdata;
    chk_data   = chk;
    exp_rdata  = exp_data;
    exp_err    = exp_fail;
    waited     = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!host_gnt && waited < WaitLimit);
    if (!host_gnt) begin
      report_timeout("host 0 grant");
    end
    @(negedge clk);
    host_req = 1'b0;
    rdata    = host_rdata;
  endtask

  task automatic sram_write(input int idx, input logic [3:0] be, input logic [31:0] data);
    logic [31:0] rd;
    bus_access(32'(idx * 4), 1'b1, be, data, 1'b0, '0, 1'b0, rd);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        model[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic sram_read(input int idx);
    logic [31:0] rd;
    bus_access(32'(idx * 4), 1'b0, 4'hf, '0, 1'b1, model[idx], 1'b0, rd);
  endtask

  task automatic start_copy(input logic [31:0] src, input logic [31:0] dst,
                            input logic [15:0] len, input logic exp_e);
    exp_copy_err = exp_e;
    copy_src     = src;
    copy_dst     = dst;
    copy_len     = len;
    copy_start   = 1'b1;
    @(negedge clk);
    copy_start   = 1'b0;
  endtask

  task automatic wait_copy_done(input int prev);
    int waited;
    waited = 0;
    while (done_cnt == prev && waited < CopyLimit) begin
      @(negedge clk);
      waited++;
    end
    if (done_cnt == prev) begin
      report_timeout("copy engine done");
    end
  endtask

  task automatic wait_irq();
    int waited;
    waited = 0;
    while (!timer_irq && waited < WaitLimit) begin
      @(negedge clk);
      waited++;
    end
    if (!timer_irq) begin
      report_timeout("timer interrupt");
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    host_req     = 1'b0;
    host_addr    = '0;
    host_we      = 1'b0;
    host_be      = '0;
    host_wdata   = '0;
    copy_start   = 1'b0;
    copy_src     = '0;
    copy_dst     = '0;
    copy_len     = '0;
    chk_data     = 1'b0;
    exp_rdata    = '0;
    exp_err      = 1'b0;
    exp_copy_err = 1'b0;
    begin : test_seq
      logic [31:0] r;
      logic [31:0] rd;
      logic [31:0] v1;
      int          prev;
      repeat (5) @(posedge clk);
      @(negedge clk);
      assert (!host_gnt && !host_rvalid && !host_err && !copy_busy && !copy_done &&
              !copy_err && !timer_irq)
        else begin
          proto_errs++;
          $display("DUT outputs are not idle during reset");
        end
      rst_n = 1'b1;
      @(negedge clk);

      // SRAM: full words, then random byte lanes, then read back
      for (int i = 768; i < 784; i++) begin
        sram_write(i, 4'hf, next_rand());
      end
      for (int i = 0; i < 32; i++) begin
        r = next_rand();
        sram_write(768 + int'(r[31:28]), r[27:24], next_rand());
      end
      for (int i = 768; i < 784; i++) begin
        sram_read(i);
      end

      // Unmapped addresses answer with err and zero data
      bus_access(32'h0002_0000, 1'b0, 4'hf, '0, 1'b1, '0, 1'b1, rd);
      bus_access(32'h0000_1000, 1'b0, 4'hf, '0, 1'b1, '0, 1'b1, rd);
      bus_access(32'h0003_0040, 1'b1, 4'hf, next_rand(), 1'b0, '0, 1'b1, rd);

      // Timer: idle count, then two reads ten cycles apart
      bus_access(TimerBase + 32'd4, 1'b0, 4'hf, '0, 1'b1, '0, 1'b0, rd);
      bus_access(TimerBase, 1'b1, 4'hf, 32'd1, 1'b0, '0, 1'b0, rd);
      bus_access(TimerBase + 32'd4, 1'b0, 4'hf, '0, 1'b0, '0, 1'b0, v1);
      repeat (9) @(negedge clk);
      bus_access(TimerBase + 32'd4, 1'b0, 4'hf, '0, 1'b1, v1 + 32'd10, 1'b0, rd);
      bus_access(TimerBase + 32'd8, 1'b1, 4'hf, rd + 32'd20, 1'b0, '0, 1'b0, rd);
      wait_irq();
      repeat (5) @(negedge clk);
      bus_access(TimerBase, 1'b1, 4'hf, 32'd1, 1'b0, '0, 1'b0, rd);
      repeat (2) @(negedge clk);
      bus_access(TimerBase, 1'b1, 4'hf, 32'd0, 1'b0, '0, 1'b0, rd);
      bus_access(TimerBase + 32'd12, 1'b0, 4'hf, '0, 1'b0, '0, 1'b1, rd);

      // Block copy of 8 words, words 0..7 to 256..263
      for (int i = 0; i < 8; i++) begin
        sram_write(i, 4'hf, next_rand());
      end
      prev = done_cnt;
      start_copy(32'h0000_0000, 32'h0000_0400, 16'd8, 1'b0);
      wait_copy_done(prev);
      for (int i = 0; i < 8; i++) begin
        model[256 + i] = model[i];
        sram_read(256 + i);
      end

      // Copy of 16 words while host 0 keeps the bus busy
      for (int i = 32; i < 48; i++) begin
        sram_write(i, 4'hf, next_rand());
      end
      prev = done_cnt;
      start_copy(32'h0000_0080, 32'h0000_0600, 16'd16, 1'b0);
      for (int i = 0; i < 24; i++) begin
        r = next_rand();
        if (r[27]) begin
          sram_write(768 + int'(r[31:28]), 4'hf, next_rand());
        end else begin
          sram_read(768 + int'(r[31:28]));
        end
      end
      wait_copy_done(prev);
      for (int i = 0; i < 16; i++) begin
        model[384 + i] = model[32 + i];
        sram_read(384 + i);
      end
      if (overlap_cnt == 0) begin
        proto_errs++;
        $display("Host 0 and the copy engine never requested in the same cycle");
      end

      // Zero length finishes at once, unmapped source ends in error
      prev = done_cnt;
      start_copy(32'h0000_0000, 32'h0000_0800, 16'd0, 1'b0);
      wait_copy_done(prev);
      @(negedge clk);
      prev = done_cnt;
      start_copy(32'h0002_0000, 32'h0000_0800, 16'd4, 1'b1);
      wait_copy_done(prev);
      repeat (3) @(negedge clk);
    end
    finish_run();
  end

endmodule
